/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_mul
RTL_TOP    = mul_top
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation FAILED"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* booth_r4_encoder.sv */
// radix-4 booth partial product generator
`timescale 1ns/1ps

`include "mul_cfg.svh"

module booth_r4_encoder
  import mul_pkg::*;
(
  input  logic [`MUL_XLEN-1:0] op1_i,
  input  logic [`MUL_XLEN-1:0] op2_i,
  input  logic                 op1_signed_i,
  input  logic                 op2_signed_i,
  output pp_array_t            pp_o
);

  // multiplicand extended by two bits, by sign or zero
  logic [`MUL_XLEN+1:0] mcand_ext;
  // multiplier extended by two bits, plus the implicit zero below bit 0
  logic [`MUL_XLEN+2:0] mplier_ext;

  // row candidates at full product width
  logic [`MUL_PLEN-1:0] mcand_x1;
  logic [`MUL_PLEN-1:0] mcand_x2;
  logic [`MUL_PLEN-1:0] mcand_n1;
  logic [`MUL_PLEN-1:0] mcand_n2;

  // window is {b[2i+1], b[2i], b[2i-1]}
  function automatic booth_op_e booth_decode(input logic [2:0] win);
    booth_op_e op;
    case (win)
      3'b001, 3'b010: op = BOOTH_POS1;
      3'b011:         op = BOOTH_POS2;
      3'b100:         op = BOOTH_NEG2;
      3'b101, 3'b110: op = BOOTH_NEG1;
      default:        op = BOOTH_ZERO;
    endcase
    return op;
  endfunction

  assign mcand_ext  = {{2{op1_signed_i & op1_i[`MUL_XLEN-1]}}, op1_i};
  assign mplier_ext = {{2{op2_signed_i & op2_i[`MUL_XLEN-1]}}, op2_i, 1'b0};

  // sign-extend the 66-bit multiplicand to the product width
  assign mcand_x1 = {{(`MUL_PLEN-`MUL_XLEN-2){mcand_ext[`MUL_XLEN+1]}}, mcand_ext};
  assign mcand_x2 = mcand_x1 << 1;

  // two's complement negation, shared by all rows
  assign mcand_n1 = ~mcand_x1 + 1'b1;
  assign mcand_n2 = ~mcand_x2 + 1'b1;

  for (genvar i = 0; i < `MUL_PP_NUM; i++) begin : g_pp
    booth_op_e            op;
    logic [`MUL_PLEN-1:0] row;

    assign op = booth_decode(mplier_ext[2*i+2 -: 3]);

    always_comb begin
      unique case (op)
        BOOTH_POS1: row = mcand_x1;
        BOOTH_POS2: row = mcand_x2;
        BOOTH_NEG1: row = mcand_n1;
        BOOTH_NEG2: row = mcand_n2;
        default:    row = '0;
      endcase
    end

    // weight of digit i is 4^i
    assign pp_o[i] = row << (2 * i);
  end

endmodule

/* csa_level.sv */
// wallace tree 3:2 compression level
`timescale 1ns/1ps

`include "mul_cfg.svh"

module csa_level #(
  parameter int ROWS_IN = 3
) (
  input  logic [ROWS_IN-1:0][`MUL_PLEN-1:0]                   rows_i,
  output logic [2*(ROWS_IN/3)+(ROWS_IN%3)-1:0][`MUL_PLEN-1:0] rows_o
);

  localparam int GROUPS = ROWS_IN / 3;
  localparam int LEFT   = ROWS_IN % 3;

  if (ROWS_IN < 3) begin : g_rows_check
    $fatal(1, "csa_level: ROWS_IN must be at least 3");
  end

  // one row of full adders per group of three
  for (genvar g = 0; g < GROUPS; g++) begin : g_csa
    logic [`MUL_PLEN-1:0] a;
    logic [`MUL_PLEN-1:0] b;
    logic [`MUL_PLEN-1:0] c;
    logic [`MUL_PLEN-1:0] sum;
    logic [`MUL_PLEN-1:0] carry;

    assign a = rows_i[3*g];
    assign b = rows_i[3*g+1];
    assign c = rows_i[3*g+2];

    assign sum   = a ^ b ^ c;
    assign carry = (a & b) | (a & c) | (b & c);

    assign rows_o[2*g] = sum;
    // carry weighs one bit more, overflow past the product is dropped
    assign rows_o[2*g+1] = {carry[`MUL_PLEN-2:0], 1'b0};
  end

  // leftover rows go after the sum/carry pairs
  for (genvar k = 0; k < LEFT; k++) begin : g_pass
    assign rows_o[2*GROUPS+k] = rows_i[3*GROUPS+k];
  end

endmodule

/* mul_cfg.svh */
// multiplier configuration
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width
`define MUL_XLEN 64

// full product width, twice the operand width
`define MUL_PLEN 128

// radix-4 booth digits over the 66-bit extended multiplier
`define MUL_PP_NUM 33

// counter value at which the product leaves the tree
// the tree has three register banks, the counter starts one cycle
// after operand capture, so the result is ready when it reads 3
`define MUL_LAST_COUNT 3

`endif

/* mul_ctrl.sv */
// multiplier sequencing and result register
`timescale 1ns/1ps

`include "mul_cfg.svh"

module mul_ctrl
  import mul_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`MUL_XLEN-1:0] rs1_data_i,
  input  logic [`MUL_XLEN-1:0] rs2_data_i,
  input  logic                 rs1_signed_i,
  input  logic                 rs2_signed_i,
  input  logic                 mul_valid_i,
  input  logic [`MUL_PLEN-1:0] product_i,
  output logic [`MUL_XLEN-1:0] op1_o,
  output logic [`MUL_XLEN-1:0] op2_o,
  output logic                 op1_signed_o,
  output logic                 op2_signed_o,
  output logic                 mul_done_o,
  output logic [`MUL_PLEN-1:0] mul_out_o
);

  localparam int CNT_W = $clog2(`MUL_LAST_COUNT + 1);

  mul_state_e           state_q;
  logic [CNT_W-1:0]     count_q;
  logic                 done_q;
  logic [`MUL_PLEN-1:0] result_q;
  logic                 start;

  // new request seen in idle
  assign start = (state_q == MUL_IDLE) && mul_valid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= MUL_IDLE;
      count_q  <= '0;
      done_q   <= 1'b0;
      result_q <= '0;
    end else begin
      unique case (state_q)
        MUL_IDLE: begin
          count_q <= '0;
          done_q  <= 1'b0;
          if (mul_valid_i) begin
            state_q <= MUL_WAIT;
          end
        end
        MUL_WAIT: begin
          if (!mul_valid_i) begin
            // request withdrawn, drop it without a pulse
            state_q <= MUL_IDLE;
          end else begin
            count_q <= count_q + 1'b1;
            if (count_q == CNT_W'(`MUL_LAST_COUNT)) begin
              result_q <= product_i;
              done_q   <= 1'b1;
              state_q  <= MUL_IDLE;
            end
          end
        end
      endcase
    end
  end

  // operands stay put while the tree works on them
  always_ff @(posedge clk) begin
    if (start) begin
      op1_o        <= rs1_data_i;
      op2_o        <= rs2_data_i;
      op1_signed_o <= rs1_signed_i;
      op2_signed_o <= rs2_signed_i;
    end
  end

  assign mul_done_o = done_q;
  assign mul_out_o  = result_q;

  // done is a single-cycle pulse
  a_done_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    mul_done_o |=> !mul_done_o
  );

  // a pulse only ever closes a wait
  a_done_from_wait: assert property (
    @(posedge clk) disable iff (rst)
    $rose(mul_done_o) |-> $past(state_q) == MUL_WAIT
  );

endmodule

/* mul_pkg.sv */
// multiplier shared types
package mul_pkg;

  `include "mul_cfg.svh"

  // controller states
  typedef enum logic [0:0] {
    MUL_IDLE = 1'b0,
    MUL_WAIT = 1'b1
  } mul_state_e;

  // booth digit operations, top bit marks a negated row
  typedef enum logic [2:0] {
    BOOTH_ZERO = 3'b000,
    BOOTH_POS1 = 3'b001,
    BOOTH_POS2 = 3'b010,
    BOOTH_NEG1 = 3'b101,
    BOOTH_NEG2 = 3'b110
  } booth_op_e;

  // one full-width row per booth digit
  typedef logic [`MUL_PP_NUM-1:0][`MUL_PLEN-1:0] pp_array_t;

endpackage

/* mul_top.sv */
// booth wallace multiplier top
`timescale 1ns/1ps

`include "mul_cfg.svh"

module mul_top
  import mul_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`MUL_XLEN-1:0] rs1_data_i,
  input  logic [`MUL_XLEN-1:0] rs2_data_i,
  input  logic                 rs1_signed_i,
  input  logic                 rs2_signed_i,
  input  logic                 mul_valid_i,
  output logic                 mul_done_o,
  output logic [`MUL_PLEN-1:0] mul_out_o
);

  // captured operands
  logic [`MUL_XLEN-1:0] op1;
  logic [`MUL_XLEN-1:0] op2;
  logic                 op1_signed;
  logic                 op2_signed;

  pp_array_t            pp;
  logic [`MUL_PLEN-1:0] product;

  mul_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .rs1_signed_i(rs1_signed_i),
    .rs2_signed_i(rs2_signed_i),
    .mul_valid_i (mul_valid_i),
    .product_i   (product),
    .op1_o       (op1),
    .op2_o       (op2),
    .op1_signed_o(op1_signed),
    .op2_signed_o(op2_signed),
    .mul_done_o  (mul_done_o),
    .mul_out_o   (mul_out_o)
  );

  booth_r4_encoder u_booth (
    .op1_i       (op1),
    .op2_i       (op2),
    .op1_signed_i(op1_signed),
    .op2_signed_i(op2_signed),
    .pp_o        (pp)
  );

  wallace_tree u_tree (
    .clk      (clk),
    .rst      (rst),
    .pp_i     (pp),
    .product_o(product)
  );

endmodule

/* sources.f */
+incdir+.
mul_pkg.sv
csa_level.sv
booth_r4_encoder.sv
wallace_tree.sv
mul_ctrl.sv
mul_top.sv
tb_mul.sv

/* tb_mul.sv */
// booth wallace multiplier testbench
`timescale 1ns/1ps

`include "mul_cfg.svh"

module tb_mul
  import mul_pkg::*;
();

  // operations issued over the whole run including the aborted one
  localparam int NUM_OPS     = 38;
  localparam int CLK_NS      = 4;
  localparam int WATCHDOG_NS = NUM_OPS * 12 * CLK_NS + 200;
  localparam int MAX_WAIT    = 10;

  logic                 clk;
  logic                 rst;
  logic [`MUL_XLEN-1:0] rs1_data;
  logic [`MUL_XLEN-1:0] rs2_data;
  logic                 rs1_signed;
  logic                 rs2_signed;
  logic                 mul_valid;
  logic                 mul_done;
  logic [`MUL_PLEN-1:0] mul_out;

  // high for the cycle in which a request that must complete is first seen
  logic                 launch;
  logic [`MUL_PLEN-1:0] exp_prod;
  logic [`MUL_PLEN-1:0] last_prod;
  string                exp_name;

  int errors;
  int tests;
  int failed;
  int seed;

  mul_top UUT (
    .clk         (clk),
    .rst         (rst),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rs1_signed_i(rs1_signed),
    .rs2_signed_i(rs2_signed),
    .mul_valid_i (mul_valid),
    .mul_done_o  (mul_done),
    .mul_out_o   (mul_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // product on every done pulse
  a_product: assert property (
    @(posedge clk) disable iff (rst)
    mul_done |-> mul_out == exp_prod
  ) else begin
    errors++;
    $display("[FAIL] %s: expected %h actual %h", exp_name, $sampled(exp_prod),
             $sampled(mul_out));
  end

  // done rises four cycles after the sampling edge and lasts one cycle
  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    launch |-> ##1 !mul_done ##1 !mul_done ##1 !mul_done ##1 !mul_done
               ##1 mul_done ##1 !mul_done
  ) else begin
    errors++;
    $display("done pulse missing or mistimed for a request, detected at %0d ns", $time);
  end

  // extend by flag, then multiply at product width
  function automatic logic [`MUL_PLEN-1:0] ref_product(input logic [`MUL_XLEN-1:0] a,
                                                       input logic [`MUL_XLEN-1:0] b,
                                                       input logic sa,
                                                       input logic sb);
    logic [`MUL_PLEN-1:0] ax;
    logic [`MUL_PLEN-1:0] bx;
    ax = {{(`MUL_PLEN-`MUL_XLEN){sa & a[`MUL_XLEN-1]}}, a};
    bx = {{(`MUL_PLEN-`MUL_XLEN){sb & b[`MUL_XLEN-1]}}, b};
    return ax * bx;
  endfunction

  function logic [`MUL_XLEN-1:0] rand64();
    rand64 = {$random(seed), $random(seed)};
  endfunction

  // expected value moves one cycle later, after any older pulse was checked
  task automatic issue(input string name, input logic [`MUL_XLEN-1:0] a,
                       input logic [`MUL_XLEN-1:0] b, input logic sa, input logic sb,
                       input logic timed);
    rs1_data   = a;
    rs2_data   = b;
    rs1_signed = sa;
    rs2_signed = sb;
    mul_valid  = 1'b1;
    launch     = timed;
    @(negedge clk);
    launch   = 1'b0;
    exp_prod = ref_product(a, b, sa, sb);
    exp_name = name;
  endtask

  task automatic wait_done(input string name);
    int  n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
      seen = mul_done;
    end
    if (!seen) begin
      errors++;
      $display("%s: no done pulse within %0d cycles of the request", name, MAX_WAIT);
    end
  endtask

  // lets the pulse checks finish before the next request
  task automatic release_valid();
    mul_valid = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic run_one(input string name, input logic [`MUL_XLEN-1:0] a,
                         input logic [`MUL_XLEN-1:0] b, input logic sa, input logic sb);
    issue(name, a, b, sa, sb, 1'b1);
    wait_done(name);
    last_prod = exp_prod;
    release_valid();
  endtask

  task automatic close_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%-14s passed", name);
    end else begin
      failed++;
      $display("%-14s failed", name);
    end
  endtask

  initial begin
    logic [`MUL_XLEN-1:0] a;
    logic [`MUL_XLEN-1:0] b;
    int                   err0;

    seed       = 95285;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    rst        = 1'b1;
    rs1_data   = '0;
    rs2_data   = '0;
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    mul_valid  = 1'b0;
    launch     = 1'b0;
    exp_prod   = '0;
    last_prod  = '0;
    exp_name   = "none";
    repeat (8) @(negedge clk);
    rst = 1'b0;

    err0 = errors;
    @(negedge clk);
    assert (mul_done == 1'b0) else begin
      errors++;
      $display("[FAIL] reset done: expected 0 actual %b", mul_done);
    end
    assert (mul_out == '0) else begin
      errors++;
      $display("[FAIL] reset product: expected %h actual %h", {`MUL_PLEN{1'b0}}, mul_out);
    end
    close_test("reset", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      a = rand64();
      b = rand64();
      run_one($sformatf("uu_rand%0d", i), a, b, 1'b0, 1'b0);
    end
    run_one("uu_ones", '1, '1, 1'b0, 1'b0);
    close_test("unsigned", err0);

    err0 = errors;
    run_one("ss_min_min", {1'b1, {(`MUL_XLEN-1){1'b0}}}, {1'b1, {(`MUL_XLEN-1){1'b0}}},
            1'b1, 1'b1);
    run_one("ss_neg1_one", '1, `MUL_XLEN'(1), 1'b1, 1'b1);
    for (int i = 0; i < 8; i++) begin
      a = rand64();
      b = rand64();
      run_one($sformatf("ss_rand%0d", i), a, b, 1'b1, 1'b1);
    end
    close_test("signed", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      a = rand64();
      b = rand64();
      run_one($sformatf("su_rand%0d", i), a, b, 1'b1, 1'b0);
      a = rand64();
      b = rand64();
      run_one($sformatf("us_rand%0d", i), a, b, 1'b0, 1'b1);
    end
    close_test("mixed", err0);

    // next request goes out in the done cycle while valid stays high
    err0 = errors;
    for (int i = 0; i < 4; i++) begin
      a = rand64();
      b = rand64();
      issue($sformatf("b2b_%0d", i), a, b, i[0], i[1], 1'b1);
      wait_done($sformatf("b2b_%0d", i));
    end
    last_prod = exp_prod;
    release_valid();
    close_test("back_to_back", err0);

    err0 = errors;
    a = rand64();
    b = rand64();
    run_one("abort_prev", a, b, 1'b1, 1'b1);
    a = rand64();
    b = rand64();
    issue("abort_drop", a, b, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    mul_valid = 1'b0;
    repeat (8) begin
      @(negedge clk);
      assert (mul_done == 1'b0) else begin
        errors++;
        $display("a done pulse appeared after the request was withdrawn");
      end
      assert (mul_out == last_prod) else begin
        errors++;
        $display("[FAIL] abort_hold: expected %h actual %h", last_prod, mul_out);
      end
    end
    assert (UUT.u_ctrl.state_q == MUL_IDLE) else begin
      errors++;
      $display("the controller did not return to idle after the abort");
    end
    a = rand64();
    b = rand64();
    run_one("abort_recover", a, b, 1'b0, 1'b1);
    close_test("abort", err0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* wallace_tree.sv */
// pipelined wallace reduction tree
`timescale 1ns/1ps

`include "mul_cfg.svh"

module wallace_tree
  import mul_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  pp_array_t            pp_i,
  output logic [`MUL_PLEN-1:0] product_o
);

  // bank 1, registered partial products
  pp_array_t pp_q;

  // first half of the reduction
  logic [21:0][`MUL_PLEN-1:0] l1_rows;
  logic [14:0][`MUL_PLEN-1:0] l2_rows;
  logic [9:0][`MUL_PLEN-1:0]  l3_rows;
  logic [6:0][`MUL_PLEN-1:0]  l4_rows;

  // bank 2, seven rows between the halves
  logic [6:0][`MUL_PLEN-1:0] mid_q;

  // second half of the reduction
  logic [4:0][`MUL_PLEN-1:0] l5_rows;
  logic [3:0][`MUL_PLEN-1:0] l6_rows;
  logic [2:0][`MUL_PLEN-1:0] l7_rows;
  logic [1:0][`MUL_PLEN-1:0] l8_rows;

  // bank 3, final sum and carry
  logic [1:0][`MUL_PLEN-1:0] fin_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pp_q <= '0;
    end else begin
      pp_q <= pp_i;
    end
  end

  // 33 -> 22 -> 15 -> 10 -> 7
  csa_level #(.ROWS_IN(`MUL_PP_NUM)) u_level1 (
    .rows_i(pp_q),
    .rows_o(l1_rows)
  );

  csa_level #(.ROWS_IN(22)) u_level2 (
    .rows_i(l1_rows),
    .rows_o(l2_rows)
  );

  csa_level #(.ROWS_IN(15)) u_level3 (
    .rows_i(l2_rows),
    .rows_o(l3_rows)
  );

  csa_level #(.ROWS_IN(10)) u_level4 (
    .rows_i(l3_rows),
    .rows_o(l4_rows)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      mid_q <= '0;
    end else begin
      mid_q <= l4_rows;
    end
  end

  // 7 -> 5 -> 4 -> 3 -> 2
  csa_level #(.ROWS_IN(7)) u_level5 (
    .rows_i(mid_q),
    .rows_o(l5_rows)
  );

  csa_level #(.ROWS_IN(5)) u_level6 (
    .rows_i(l5_rows),
    .rows_o(l6_rows)
  );

  csa_level #(.ROWS_IN(4)) u_level7 (
    .rows_i(l6_rows),
    .rows_o(l7_rows)
  );

  csa_level #(.ROWS_IN(3)) u_level8 (
    .rows_i(l7_rows),
    .rows_o(l8_rows)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      fin_q <= '0;
    end else begin
      fin_q <= l8_rows;
    end
  end

  // carry-propagate add, wraps at the product width
  assign product_o = fin_q[0] + fin_q[1];

endmodule
